//--- hw/out_bank_ctrl.sv
`default_nettype none

module out_bank_ctrl (
  input  logic clk,
  input  logic rstn,
  input  logic i_frame_done,
  input  logic i_done_proc,
  output logic o_wr_free,
  output logic o_wr_bank,
  output logic o_rd_bank,
  output logic o_done_fill
);

  // read side sequence
  // bank written -> pulse done_fill -> host reads -> host toggles done_proc -> release bank
  typedef enum logic [2:0] {
    R_IDLE,
    R_DONE_FILL,
    R_READ,
    R_WAIT,
    R_SWITCH
  } rd_state_t;

  rd_state_t state, state_next;

  logic [1:0] bank_written; // holds a full frame not yet handed back
  logic [1:0] bank_read;    // free for the writer
  logic       wr_bank;
  logic       rd_bank;
  logic       dp_prev;      // done_proc level seen at the end of the last read

  always_comb begin
    state_next = state;
    case (state)
      R_IDLE:      if (bank_written[rd_bank]) state_next = R_DONE_FILL;
      R_DONE_FILL: state_next = R_READ;
      R_READ:      if (dp_prev != i_done_proc) state_next = R_WAIT;
      R_WAIT:      state_next = R_SWITCH;
      R_SWITCH:    state_next = R_IDLE;
      default:     state_next = R_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) state <= R_IDLE;
    else       state <= state_next;
  end

  // write side flips as soon as the writer reports a full bank
  always_ff @(posedge clk) begin
    if (!rstn)             wr_bank <= 1'b0;
    else if (i_frame_done) wr_bank <= ~wr_bank;
  end

  always_ff @(posedge clk) begin
    if (!rstn)                   rd_bank <= 1'b0;
    else if (state == R_SWITCH)  rd_bank <= ~rd_bank;
  end

  always_ff @(posedge clk) begin
    if (!rstn)                                    dp_prev <= 1'b0;
    else if (state == R_READ && state_next == R_WAIT) dp_prev <= i_done_proc;
  end

  // the writer never touches the bank being read, so the indices do not collide
  always_ff @(posedge clk) begin
    if (!rstn) begin
      bank_written <= 2'b00;
      bank_read    <= 2'b11;
    end else begin
      if (i_frame_done)
        bank_written[wr_bank] <= 1'b1;
      if (state == R_DONE_FILL)
        bank_read[rd_bank] <= 1'b0; // host owns it now
      if (state == R_SWITCH) begin
        bank_written[rd_bank] <= 1'b0;
        bank_read[rd_bank]    <= 1'b1;
      end
    end
  end

  assign o_wr_free   = bank_read[wr_bank];
  assign o_wr_bank   = wr_bank;
  assign o_rd_bank   = rd_bank;
  assign o_done_fill = (state == R_DONE_FILL);

endmodule

`default_nettype wire

//--- hw/out_bank_ram.sv
`default_nettype none

`include "out_buf_config.svh"

module out_bank_ram (
  input  logic                clk,
  input  logic                i_wr_en,
  input  out_buf_pkg::waddr_t i_wr_addr,
  input  out_buf_pkg::y_t     i_wr_data,
  input  logic                i_rd_en,
  input  out_buf_pkg::waddr_t i_rd_addr,
  output out_buf_pkg::y_t     o_rd_data
);

  localparam int DEPTH   = `OUT_COLS * `OUT_ROWS;
  localparam int DEPTH_W = $clog2(DEPTH);

  out_buf_pkg::y_t mem [DEPTH];

  logic [DEPTH_W-1:0] rd_addr_q;

  always_ff @(posedge clk) begin
    if (i_wr_en) mem[i_wr_addr[DEPTH_W-1:0]] <= i_wr_data;
  end

  // address register plus output register, two cycles to data
  always_ff @(posedge clk) begin
    if (i_rd_en) rd_addr_q <= i_rd_addr[DEPTH_W-1:0];
  end

  always_ff @(posedge clk) begin
    o_rd_data <= mem[rd_addr_q];
  end

endmodule

`default_nettype wire

//--- hw/out_buf_config.svh
`ifndef OUT_BUF_CONFIG_SVH
`define OUT_BUF_CONFIG_SVH

// values delivered per beat by the compute engine
`define OUT_ROWS 4

// max beats in one frame, sets the bank depth together with OUT_ROWS
`define OUT_COLS 8

`define OUT_Y_BITS 16 // signed result width

// word address into one bank, host side adds two byte bits on top
`define OUT_ADDR_WIDTH 10

// cycles from host enable to data on o_ram_rddata
`define OUT_RAM_LATENCY 2

`endif

//--- hw/out_buf_pkg.sv
`default_nettype none

`include "out_buf_config.svh"

package out_buf_pkg;

  // one result value from the engine
  typedef logic signed [`OUT_Y_BITS-1:0] y_t;

  // one input beat, element 0 sits in the low bits and is written first
  typedef y_t [`OUT_ROWS-1:0] row_t;

  typedef logic [`OUT_ADDR_WIDTH-1:0] waddr_t; // word address in a bank

  // host side is byte addressed
  typedef logic [`OUT_ADDR_WIDTH+1:0] haddr_t;

  typedef logic [31:0] hword_t; // sign-extended read word

endpackage

`default_nettype wire

//--- hw/out_buf_top.sv
`default_nettype none

module out_buf_top (
  input  logic                clk,
  input  logic                rstn,
  // engine side
  input  logic                i_s_valid,
  input  out_buf_pkg::row_t   i_s_data,
  input  logic                i_s_last,
  output logic                o_s_ready,
  // host side
  input  logic                i_ram_en,
  input  out_buf_pkg::haddr_t i_ram_addr,
  output out_buf_pkg::hword_t o_ram_rddata,
  output logic                o_done_fill,
  input  logic                i_done_proc
);

  logic                wr_en;
  out_buf_pkg::waddr_t wr_addr;
  out_buf_pkg::y_t     wr_data;
  logic                frame_done;
  logic                wr_free;
  logic                wr_bank;
  logic                rd_bank;
  out_buf_pkg::waddr_t rd_addr;
  out_buf_pkg::y_t     bank_data [2];

  out_row_writer u_writer (
    .clk          (clk),
    .rstn         (rstn),
    .i_s_valid    (i_s_valid),
    .i_s_data     (i_s_data),
    .i_s_last     (i_s_last),
    .i_wr_free    (wr_free),
    .o_s_ready    (o_s_ready),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data),
    .o_frame_done (frame_done)
  );

  out_bank_ctrl u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .i_frame_done (frame_done),
    .i_done_proc  (i_done_proc),
    .o_wr_free    (wr_free),
    .o_wr_bank    (wr_bank),
    .o_rd_bank    (rd_bank),
    .o_done_fill  (o_done_fill)
  );

  // both banks see the host address, only the write bank takes the strobe
  for (genvar g = 0; g < 2; g++) begin : g_bank
    out_bank_ram u_ram (
      .clk       (clk),
      .i_wr_en   (wr_en && (wr_bank == 1'(g))),
      .i_wr_addr (wr_addr),
      .i_wr_data (wr_data),
      .i_rd_en   (i_ram_en),
      .i_rd_addr (rd_addr),
      .o_rd_data (bank_data[g])
    );
  end

  out_host_read u_host_read (
    .clk          (clk),
    .rstn         (rstn),
    .i_ram_en     (i_ram_en),
    .i_ram_addr   (i_ram_addr),
    .i_rd_bank    (rd_bank),
    .i_bank0_data (bank_data[0]),
    .i_bank1_data (bank_data[1]),
    .o_rd_addr    (rd_addr),
    .o_ram_rddata (o_ram_rddata)
  );

endmodule

`default_nettype wire

//--- hw/out_host_read.sv
`default_nettype none

`include "out_buf_config.svh"

module out_host_read (
  input  logic                clk,
  input  logic                rstn,
  input  logic                i_ram_en,
  input  out_buf_pkg::haddr_t i_ram_addr,
  input  logic                i_rd_bank,
  input  out_buf_pkg::y_t     i_bank0_data,
  input  out_buf_pkg::y_t     i_bank1_data,
  output out_buf_pkg::waddr_t o_rd_addr,
  output out_buf_pkg::hword_t o_ram_rddata
);

  localparam int LAT    = `OUT_RAM_LATENCY;
  localparam int Y_BITS = `OUT_Y_BITS;

  logic [LAT-1:0]  bank_pipe;  // read bank captured with the address and delayed like the RAM data
  logic            bank_issue; // read bank of the last enabled address
  out_buf_pkg::y_t sel_data;

  assign o_rd_addr = i_ram_addr[`OUT_ADDR_WIDTH+1:2]; // byte to word

  // first stage holds like the RAM address register
  assign bank_issue = i_ram_en ? i_rd_bank : bank_pipe[0];

  always_ff @(posedge clk) begin
    if (!rstn)         bank_pipe <= '0;
    else if (LAT == 1) bank_pipe <= bank_issue;
    else               bank_pipe <= {bank_pipe[LAT-2:0], bank_issue};
  end

  assign sel_data = bank_pipe[LAT-1] ? i_bank1_data : i_bank0_data;

  assign o_ram_rddata = {{(32 - Y_BITS){sel_data[Y_BITS-1]}}, sel_data};

endmodule

`default_nettype wire

//--- hw/out_row_writer.sv
`default_nettype none

`include "out_buf_config.svh"

module out_row_writer (
  input  logic                clk,
  input  logic                rstn,
  input  logic                i_s_valid,
  input  out_buf_pkg::row_t   i_s_data,
  input  logic                i_s_last,
  input  logic                i_wr_free,
  output logic                o_s_ready,
  output logic                o_wr_en,
  output out_buf_pkg::waddr_t o_wr_addr,
  output out_buf_pkg::y_t     o_wr_data,
  output logic                o_frame_done
);

  localparam int ROWS   = `OUT_ROWS;
  localparam int Y_BITS = `OUT_Y_BITS;
  localparam int CNT_W  = (ROWS > 1) ? $clog2(ROWS) : 1;

  typedef enum logic [1:0] {
    W_IDLE,
    W_WRITE,
    W_FILL,
    W_SWITCH
  } wr_state_t;

  wr_state_t state, state_next;

  logic              first_beat; // no beat loaded yet in this frame
  logic              last_beat;  // beat in the shift register carries the last flag
  logic              take;
  logic              en_shift;
  logic              row_last;
  logic              row_done;
  logic [CNT_W-1:0]  row_cnt;
  out_buf_pkg::row_t shift_reg;

  assign take     = i_s_valid && o_s_ready;
  assign row_last = (row_cnt == CNT_W'(ROWS - 1));

  // on the final element of a beat, wait for the next beat unless the frame ends here
  assign en_shift = (state == W_WRITE) && !first_beat &&
                    (row_last ? (i_s_valid || last_beat) : 1'b1);
  assign row_done = row_last && en_shift;

  always_comb begin
    state_next = state;
    case (state)
      W_IDLE:   if (i_wr_free) state_next = W_WRITE;
      W_WRITE:  if (row_done && last_beat) state_next = W_FILL;
      W_FILL:   state_next = W_SWITCH;
      W_SWITCH: state_next = W_IDLE;
      default:  state_next = W_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) state <= W_IDLE;
    else       state <= state_next;
  end

  // ready for the first beat, then again on the last element of each beat
  assign o_s_ready = (state == W_WRITE) && (state_next == W_WRITE) &&
                     (first_beat || row_last);

  always_ff @(posedge clk) begin
    if (!rstn || state == W_FILL) first_beat <= 1'b1;
    else if (take)                first_beat <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rstn)     last_beat <= 1'b0;
    else if (take) last_beat <= i_s_last;
  end

  always_ff @(posedge clk) begin
    if (!rstn || state == W_IDLE) row_cnt <= '0;
    else if (en_shift)            row_cnt <= row_last ? '0 : row_cnt + 1'b1;
  end

  // word address just counts written values across the frame
  always_ff @(posedge clk) begin
    if (!rstn || state == W_IDLE) o_wr_addr <= '0;
    else if (en_shift)            o_wr_addr <= o_wr_addr + 1'b1;
  end

  // a new beat overrides the shift, both land on the same edge when streaming
  always_ff @(posedge clk) begin
    if (take)          shift_reg <= i_s_data;
    else if (en_shift) shift_reg <= out_buf_pkg::row_t'(shift_reg >> Y_BITS);
  end

  assign o_wr_en      = en_shift;
  assign o_wr_data    = shift_reg[0];
  assign o_frame_done = (state == W_SWITCH); // one cycle, bank is complete

endmodule

`default_nettype wire

//--- out_buf_top.f
+incdir+hw
hw/out_buf_pkg.sv
hw/out_row_writer.sv
hw/out_bank_ctrl.sv
hw/out_bank_ram.sv
hw/out_host_read.sv
hw/out_buf_top.sv
testbench/out_buf_properties.sv
testbench/tb_out_buf.sv

//--- testbench/out_buf_properties.sv
`default_nettype none

module out_buf_properties (
  input logic clk,
  input logic rstn,
  input logic o_s_ready,
  input logic o_done_fill
);

  int unsigned fail_count; // the testbench reads this at the end of the run
  bit          rst_q;      // rstn was already low on the previous edge

  always @(posedge clk) rst_q <= !rstn;

  // a fill strobe is one cycle wide
  a_fill_pulse: assert property (
    @(posedge clk) disable iff (!rstn) o_done_fill |=> !o_done_fill
  ) else begin
    $error("o_done_fill high on two consecutive cycles");
    fail_count++;
  end

  // outputs settle one edge into reset, so the first edge is skipped
  a_ready_in_reset: assert property (@(posedge clk) (!rstn && rst_q) |-> !o_s_ready)
  else begin
    $error("o_s_ready high while rstn is low");
    fail_count++;
  end

  a_fill_in_reset: assert property (@(posedge clk) (!rstn && rst_q) |-> !o_done_fill)
  else begin
    $error("o_done_fill high while rstn is low");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- testbench/tb_out_buf.sv
`default_nettype none

`include "out_buf_config.svh"

module tb_out_buf;

  localparam int ROWS    = `OUT_ROWS;
  localparam int LAT     = `OUT_RAM_LATENCY;
  localparam int TIMEOUT = 200; // cycles allowed for any single wait

  logic                clk;
  logic                rstn;
  logic                i_s_valid;
  out_buf_pkg::row_t   i_s_data;
  logic                i_s_last;
  logic                o_s_ready;
  logic                i_ram_en;
  out_buf_pkg::haddr_t i_ram_addr;
  out_buf_pkg::hword_t o_ram_rddata;
  logic                o_done_fill;
  logic                i_done_proc;

  logic [31:0] lfsr = 32'h1f18167b;
  int          errors;
  int          tests;
  int          test_errs; // error count when the current test started
  int          fills;     // o_done_fill pulses seen
  int          exp_fills;

  out_buf_top out_buf_top_i (.*);

  bind out_buf_top out_buf_properties props_i (
    .clk         (clk),
    .rstn        (rstn),
    .o_s_ready   (o_s_ready),
    .o_done_fill (o_done_fill)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rstn && o_done_fill) fills++;
  end

  // taps of x^32 + x^22 + x^2 + x + 1 and one shift per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // host sees the signed value widened to 32 bits
  function automatic out_buf_pkg::hword_t widen(input out_buf_pkg::y_t v);
    int s;
    s = v;
    return out_buf_pkg::hword_t'(s);
  endfunction

  function automatic out_buf_pkg::row_t make_row(input out_buf_pkg::y_t vals[$], input int b);
    out_buf_pkg::row_t row;
    for (int r = 0; r < ROWS; r++) row[r] = vals[b * ROWS + r]; // element 0 goes first
    return row;
  endfunction

  task automatic check_word(input string name, input out_buf_pkg::hword_t got,
                            input out_buf_pkg::hword_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timed out waiting for %s", what);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%-16s %s, %0d errors", name, (errors == test_errs) ? "pass" : "fail",
             errors - test_errs);
    test_errs = errors;
  endtask

  // returns once ready is seen, the beat is taken on the next rising edge
  task automatic push_beat(input out_buf_pkg::row_t row, input bit last);
    int n;
    @(posedge clk);
    i_s_valid <= 1'b1;
    i_s_data  <= row;
    i_s_last  <= last;
    n = 0;
    @(negedge clk);
    while (!o_s_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_s_ready) report_timeout("o_s_ready");
  endtask

  task automatic send_frame(input out_buf_pkg::y_t vals[$], input bit gaps);
    int nbeats;
    int gap;
    nbeats = vals.size() / ROWS;
    for (int b = 0; b < nbeats; b++) begin
      gap = gaps ? rand_bits(2) : 0;
      if (gap > 0) begin
        @(posedge clk);
        i_s_valid <= 1'b0;
        repeat (gap - 1) @(posedge clk);
      end
      push_beat(make_row(vals, b), b == nbeats - 1);
    end
    @(posedge clk); // last beat taken here
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
  endtask

  task automatic wait_fill();
    int n;
    exp_fills++;
    n = 0;
    while (fills < exp_fills && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (fills < exp_fills) report_timeout("o_done_fill");
  endtask

  // one address per cycle, data checked LAT cycles after its address
  task automatic read_frame(input out_buf_pkg::y_t vals[$]);
    int n;
    n = vals.size();
    for (int j = 0; j < n + LAT; j++) begin
      @(posedge clk);
      i_ram_en   <= (j < n);
      i_ram_addr <= out_buf_pkg::haddr_t'(j * 4);
      @(negedge clk);
      if (j >= LAT)
        check_word($sformatf("o_ram_rddata[%0d]", j - LAT), o_ram_rddata, widen(vals[j - LAT]));
    end
  endtask

  task automatic toggle_proc();
    @(posedge clk);
    i_done_proc <= ~i_done_proc;
  endtask

  task automatic single_frame();
    out_buf_pkg::y_t q[$];
    for (int k = 0; k < 3 * ROWS; k++) q.push_back(out_buf_pkg::y_t'(k));
    send_frame(q, 1'b0);
    wait_fill();
    read_frame(q);
    repeat (10) @(posedge clk);
    check_flag("one o_done_fill", fills == exp_fills, 1'b1);
    toggle_proc();
    end_test("single_frame");
  endtask

  task automatic fill_timing();
    out_buf_pkg::y_t q[$];
    for (int k = 0; k < 2 * ROWS; k++) q.push_back(out_buf_pkg::y_t'(100 - 20 * k));
    push_beat(make_row(q, 0), 1'b0);
    @(posedge clk);
    i_s_valid <= 1'b0; // writer stalls on the last element of beat 0
    repeat (12) begin
      @(negedge clk);
      check_flag("o_done_fill before last beat", o_done_fill, 1'b0);
    end
    push_beat(make_row(q, 1), 1'b1);
    @(posedge clk);
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
    repeat (ROWS) begin
      @(negedge clk);
      check_flag("o_done_fill while draining", o_done_fill, 1'b0);
    end
    wait_fill();
    read_frame(q);
    repeat (10) @(posedge clk);
    check_flag("one o_done_fill per frame", fills == exp_fills, 1'b1);
    toggle_proc();
    end_test("fill_timing");
  endtask

  task automatic ping_pong();
    out_buf_pkg::y_t qa[$];
    out_buf_pkg::y_t qb[$];
    for (int k = 0; k < 2 * ROWS; k++) qa.push_back(out_buf_pkg::y_t'(16'h0200 + k));
    for (int k = 0; k < 3 * ROWS; k++) qb.push_back(out_buf_pkg::y_t'(-k - 1));
    send_frame(qa, 1'b0);
    wait_fill();
    send_frame(qb, 1'b0); // goes to the other bank while qa is held
    repeat (10) @(posedge clk);
    check_flag("no o_done_fill while host holds bank", fills == exp_fills, 1'b1);
    read_frame(qa);
    toggle_proc();
    wait_fill();
    read_frame(qb);
    toggle_proc();
    end_test("ping_pong");
  endtask

  task automatic back_pressure();
    out_buf_pkg::y_t q1[$];
    out_buf_pkg::y_t q2[$];
    out_buf_pkg::y_t q3[$];
    for (int k = 0; k < 4 * ROWS; k++) begin
      q1.push_back(out_buf_pkg::y_t'(16'h1000 + k));
      q2.push_back(out_buf_pkg::y_t'(16'h2000 + k));
      q3.push_back(out_buf_pkg::y_t'(16'hf000 + k));
    end
    send_frame(q1, 1'b0);
    wait_fill();
    send_frame(q2, 1'b0);
    @(posedge clk);
    i_s_valid <= 1'b1;
    i_s_data  <= make_row(q3, 0);
    repeat (30) begin
      @(negedge clk);
      check_flag("o_s_ready with both banks full", o_s_ready, 1'b0);
    end
    @(posedge clk);
    i_s_valid <= 1'b0;
    read_frame(q1);
    toggle_proc();
    send_frame(q3, 1'b0);
    wait_fill(); // q2 offered to the host once q1 is released
    read_frame(q2);
    toggle_proc();
    wait_fill();
    read_frame(q3);
    toggle_proc();
    end_test("back_pressure");
  endtask

  task automatic random_gaps();
    out_buf_pkg::y_t q[$];
    out_buf_pkg::y_t v;
    bit              neg;
    for (int f = 0; f < 2; f++) begin
      q   = {};
      neg = 1'b0;
      for (int k = 0; k < 6 * ROWS; k++) begin
        v = out_buf_pkg::y_t'(rand_bits(`OUT_Y_BITS));
        q.push_back(v);
        if (v < 0) neg = 1'b1;
      end
      check_flag("negative values in stimulus", neg, 1'b1);
      send_frame(q, 1'b1);
      wait_fill();
      read_frame(q);
      toggle_proc();
    end
    end_test("random_gaps");
  endtask

  initial begin
    rstn        <= 1'b0;
    i_s_valid   <= 1'b0;
    i_s_data    <= '0;
    i_s_last    <= 1'b0;
    i_ram_en    <= 1'b0;
    i_ram_addr  <= '0;
    i_done_proc <= 1'b0;
    errors    = 0;
    tests     = 0;
    test_errs = 0;
    fills     = 0;
    exp_fills = 0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    single_frame();
    fill_timing();
    ping_pong();
    back_pressure();
    random_gaps();
    repeat (5) @(posedge clk);
    check_flag("bound assertions clean", out_buf_top_i.props_i.fail_count == 0, 1'b1);
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
